// File: Makefile
# Verilator build and run of the Sobel edge detector testbench
# every variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_edge_sobel
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: include/sobel_settings.svh
// pixel width, line buffer depth and edge threshold for the Sobel pipeline
`ifndef SOBEL_SETTINGS_SVH
`define SOBEL_SETTINGS_SVH

// bits per pixel on the video stream
`define PIXEL_WIDTH 8

// longest line the two line buffers can hold
`define MAX_LINE_WIDTH 64

// magnitudes above this value are drawn as full white
`define EDGE_THRESHOLD 127

`endif

// File: src.f
+incdir+include
verilog/sobel_pkg.sv
verilog/sobel_window_if.sv
verilog/sobel_grad_if.sv
verilog/window_decode.sv
verilog/gradient_execute.sv
verilog/edge_result.sv
verilog/edge_sobel_top.sv
testbench/tb_edge_sobel.sv

// File: testbench/tb_edge_sobel.sv
// testbench for the Sobel edge detector
// random frames from a fixed seed, reference model, sync and pixel checks, watchdog
`timescale 1ns/1ps
`include "sobel_settings.svh"

module tb_edge_sobel;

    localparam int ClkPeriod = 4;
    localparam int MaxRows   = 8;
    localparam int NumFrames = 11;
    localparam int WhitePix  = (1 << `PIXEL_WIDTH) - 1;

    // frame fill patterns
    localparam int PatRandom   = 0;
    localparam int PatSoft     = 1;
    localparam int PatFlat     = 2;
    localparam int PatVertRise = 3;
    localparam int PatVertFall = 4;
    localparam int PatHorRise  = 5;
    localparam int PatHorFall  = 6;

    logic              pclk = 1'b0;
    logic              rstN;
    logic              fsyncIn;
    logic              rsyncIn;
    sobel_pkg::pixel_t pixelIn;
    logic              fsyncOut;
    logic              rsyncOut;
    sobel_pkg::pixel_t pixelOut;

    logic [31:0]       rngState = 32'h6021;
    sobel_pkg::pixel_t frame [MaxRows][`MAX_LINE_WIDTH];
    int                frameW [NumFrames];
    int                frameH [NumFrames];
    sobel_pkg::pixel_t expQ [$];
    // set where the whole window lies inside the frame
    bit                interiorQ [$];
    logic [1:0]        syncHist [3];
    sobel_pkg::pixel_t lastPixel;
    sobel_pkg::pixel_t expPix;
    bit                expInterior;

    logic monitorOn     = 1'b0;
    logic scheduleReady = 1'b0;
    int   budgetCycles  = 0;
    int   errorCount     = 0;
    int   syncErrorCount = 0;
    int   passCount      = 0;
    int   failCount      = 0;
    int   whiteCount     = 0;
    int   zeroCount      = 0;

    edge_sobel_top u_dut (
        .pclk_i  (pclk),
        .rstN_i  (rstN),
        .fsync_i (fsyncIn),
        .rsync_i (rsyncIn),
        .pixel_i (pixelIn),
        .fsync_o (fsyncOut),
        .rsync_o (rsyncOut),
        .pixel_o (pixelOut)
    );

    always #(ClkPeriod / 2) pclk = ~pclk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // next generator value mapped onto lo..hi
    function automatic int randRange(input int lo, input int hi);
        rngState = xorshift32(rngState);
        return lo + int'(rngState % 32'(hi - lo + 1));
    endfunction

    // neighbours above or left of the frame are zero
    function automatic int pixAt(input int r, input int c);
        if (r < 0 || c < 0) begin
            return 0;
        end
        return int'(frame[r][c]);
    endfunction

    // expected output for the window whose newest pixel sits at (r, c)
    function automatic int expectedPixel(input int r, input int c);
        int gx;
        int gy;
        int mag;
        gx = (pixAt(r - 2, c) + 2 * pixAt(r - 1, c) + pixAt(r, c))
           - (pixAt(r - 2, c - 2) + 2 * pixAt(r - 1, c - 2) + pixAt(r, c - 2));
        gy = (pixAt(r, c - 2) + 2 * pixAt(r, c - 1) + pixAt(r, c))
           - (pixAt(r - 2, c - 2) + 2 * pixAt(r - 2, c - 1) + pixAt(r - 2, c));
        mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
        if (mag > `EDGE_THRESHOLD) begin
            return WhitePix;
        end
        return mag;
    endfunction

    // frame sizes are drawn up front so the watchdog knows the run length
    task automatic planFrames();
        budgetCycles = 20 + 5 * 20;
        for (int i = 0; i < NumFrames; i++) begin
            frameW[i] = randRange(3, `MAX_LINE_WIDTH);
            frameH[i] = randRange(3, MaxRows);
            // worst case line gap of 5 and frame gap of 6
            budgetCycles += frameH[i] * (frameW[i] + 5) + 7;
        end
    endtask

    task automatic fillFrame(input int mode, input int w, input int h);
        int flatVal;
        flatVal = randRange(1, WhitePix);
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                case (mode)
                    PatSoft:     frame[r][c] = sobel_pkg::pixel_t'(randRange(0, 31));
                    PatFlat:     frame[r][c] = sobel_pkg::pixel_t'(flatVal);
                    PatVertRise: frame[r][c] = (c < w / 2) ? '0 : '1;
                    PatVertFall: frame[r][c] = (c < w / 2) ? '1 : '0;
                    PatHorRise:  frame[r][c] = (r < h / 2) ? '0 : '1;
                    PatHorFall:  frame[r][c] = (r < h / 2) ? '1 : '0;
                    default:     frame[r][c] = sobel_pkg::pixel_t'(randRange(0, WhitePix));
                endcase
            end
        end
    endtask

    // drives one frame with random line and frame blanking
    task automatic driveFrame(input int w, input int h);
        int gap;
        for (int r = 0; r < h; r++) begin
            for (int c = 0; c < w; c++) begin
                @(posedge pclk);
                fsyncIn <= 1'b1;
                rsyncIn <= 1'b1;
                pixelIn <= frame[r][c];
                expQ.push_back(sobel_pkg::pixel_t'(expectedPixel(r, c)));
                interiorQ.push_back(r >= 2 && c >= 2);
            end
            if (r < h - 1) begin
                gap = randRange(1, 5);
                repeat (gap) begin
                    @(posedge pclk);
                    rsyncIn <= 1'b0;
                    pixelIn <= sobel_pkg::pixel_t'(randRange(0, WhitePix));
                end
            end
        end
        gap = randRange(2, 6);
        repeat (gap) begin
            @(posedge pclk);
            fsyncIn <= 1'b0;
            rsyncIn <= 1'b0;
            pixelIn <= sobel_pkg::pixel_t'(randRange(0, WhitePix));
        end
    endtask

    task automatic runFrame(input int idx, input int mode);
        fillFrame(mode, frameW[idx], frameH[idx]);
        driveFrame(frameW[idx], frameH[idx]);
    endtask

    // wait until every expected pixel has come out of the pipeline
    task automatic drainPipeline();
        for (int i = 0; i < 16 && expQ.size() != 0; i++) begin
            @(posedge pclk);
        end
        repeat (4) @(posedge pclk);
        assert (expQ.size() == 0) else begin
            $display("%0d expected pixels were never produced by the DUT", expQ.size());
            errorCount++;
        end
    endtask

    task automatic finishTest(input string name, input int newErrors);
        if (newErrors == 0) begin
            passCount++;
            $display("test %s: passed", name);
        end else begin
            failCount++;
            $display("test %s: failed with %0d errors", name, newErrors);
        end
    endtask

    // output monitor samples at the falling edge where everything is stable
    always @(negedge pclk) begin
        if (monitorOn) begin
            assert (fsyncOut == syncHist[2][1]) else begin
                $display("ERROR time=%0t signal=fsync_o expected=%0b actual=%0b",
                         $time, syncHist[2][1], fsyncOut);
                errorCount++;
                syncErrorCount++;
            end
            assert (rsyncOut == syncHist[2][0]) else begin
                $display("ERROR time=%0t signal=rsync_o expected=%0b actual=%0b",
                         $time, syncHist[2][0], rsyncOut);
                errorCount++;
                syncErrorCount++;
            end
            if (fsyncOut && rsyncOut) begin
                assert (expQ.size() != 0) else begin
                    $display("output pixel at time %0t has no expected value in the model",
                             $time);
                    errorCount++;
                end
                if (expQ.size() != 0) begin
                    expPix      = expQ.pop_front();
                    expInterior = interiorQ.pop_front();
                    assert (pixelOut == expPix) else begin
                        $display("ERROR time=%0t signal=pixel_o expected=%0h actual=%0h",
                                 $time, expPix, pixelOut);
                        errorCount++;
                    end
                    if (expInterior && pixelOut == '1) begin
                        whiteCount++;
                    end
                    if (expInterior && pixelOut == '0) begin
                        zeroCount++;
                    end
                end
            end else begin
                // the pixel holds while the output is not valid
                assert (pixelOut == lastPixel) else begin
                    $display("ERROR time=%0t signal=pixel_o expected=%0h actual=%0h",
                             $time, lastPixel, pixelOut);
                    errorCount++;
                    syncErrorCount++;
                end
            end
            syncHist[2] = syncHist[1];
            syncHist[1] = syncHist[0];
            syncHist[0] = {fsyncIn, rsyncIn};
            lastPixel   = pixelOut;
        end
    end

    initial begin
        wait (scheduleReady);
        #(2 * budgetCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles with the tests still running",
                 2 * budgetCycles);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        int startErrors;
        int startCount;
        rstN      = 1'b0;
        fsyncIn   = 1'b0;
        rsyncIn   = 1'b0;
        pixelIn   = '0;
        lastPixel = '0;
        for (int i = 0; i < 3; i++) begin
            syncHist[i] = 2'b00;
        end
        planFrames();
        scheduleReady = 1'b1;

        repeat (10) @(posedge pclk);
        rstN      <= 1'b1;
        monitorOn = 1'b1;

        // outputs stay quiet after reset and before any frame
        startErrors = errorCount;
        repeat (5) begin
            @(negedge pclk);
            assert (fsyncOut == 1'b0) else begin
                $display("ERROR time=%0t signal=fsync_o expected=0 actual=%0b", $time, fsyncOut);
                errorCount++;
            end
            assert (rsyncOut == 1'b0) else begin
                $display("ERROR time=%0t signal=rsync_o expected=0 actual=%0b", $time, rsyncOut);
                errorCount++;
            end
            assert (pixelOut == '0) else begin
                $display("ERROR time=%0t signal=pixel_o expected=0 actual=%0h", $time, pixelOut);
                errorCount++;
            end
        end
        finishTest("reset", errorCount - startErrors);

        startErrors = errorCount;
        startCount  = zeroCount;
        runFrame(0, PatFlat);
        drainPipeline();
        assert (zeroCount > startCount) else begin
            $display("flat frame gave no zero pixel inside the frame");
            errorCount++;
        end
        finishTest("flat image", errorCount - startErrors);

        startErrors = errorCount;
        startCount  = whiteCount;
        runFrame(1, PatVertRise);
        runFrame(2, PatVertFall);
        runFrame(3, PatHorRise);
        runFrame(4, PatHorFall);
        drainPipeline();
        assert (whiteCount > startCount) else begin
            $display("step frames gave no white pixel away from the frame border");
            errorCount++;
        end
        finishTest("strong edges", errorCount - startErrors);

        // soft frames keep many sums under the threshold
        startErrors = errorCount;
        for (int i = 5; i < NumFrames; i++) begin
            runFrame(i, (i % 2 == 1) ? PatRandom : PatSoft);
        end
        drainPipeline();
        finishTest("random frames", errorCount - startErrors);

        finishTest("sync delay", syncErrorCount);

        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/edge_result.sv
// result stage of the Sobel pipeline
// |Gx| + |Gy|, threshold to white and the output register
`timescale 1ns/1ps
`include "sobel_settings.svh"

module edge_result (
    input  logic              pclk_i,
    input  logic              rstN_i,
    sobel_grad_if.result      grad,
    output logic              fsync_o,
    output logic              rsync_o,
    output sobel_pkg::pixel_t pixel_o
);

    logic            gradValid;
    sobel_pkg::mag_t absX;
    sobel_pkg::mag_t absY;
    sobel_pkg::mag_t magSum;
    logic            isEdge;

    assign gradValid = grad.fsync && grad.rsync;

    // the sign bit picks the negated value, -1020 still fits in 12 bits
    assign absX = grad.gx[$bits(sobel_pkg::grad_t)-1] ? sobel_pkg::mag_t'(-grad.gx)
                                                      : sobel_pkg::mag_t'(grad.gx);
    assign absY = grad.gy[$bits(sobel_pkg::grad_t)-1] ? sobel_pkg::mag_t'(-grad.gy)
                                                      : sobel_pkg::mag_t'(grad.gy);

    // at most 2040, no carry out of 12 bits
    assign magSum = absX + absY;
    assign isEdge = magSum > sobel_pkg::mag_t'(`EDGE_THRESHOLD);

    always_ff @(posedge pclk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            fsync_o <= 1'b0;
            rsync_o <= 1'b0;
            pixel_o <= '0;
        end else begin
            fsync_o <= grad.fsync;
            rsync_o <= grad.rsync;
            if (gradValid) begin
                // below the threshold the sum fits the pixel width
                if (isEdge) begin
                    pixel_o <= '1;
                end else begin
                    pixel_o <= magSum[`PIXEL_WIDTH-1:0];
                end
            end
        end
    end

endmodule

// File: verilog/edge_sobel_top.sv
// top level of the Sobel edge detector
// decode, execute and result stages joined by the window and gradient interfaces
`timescale 1ns/1ps

module edge_sobel_top (
    input  logic              pclk_i,
    input  logic              rstN_i,
    input  logic              fsync_i,
    input  logic              rsync_i,
    input  sobel_pkg::pixel_t pixel_i,
    output logic              fsync_o,
    output logic              rsync_o,
    output sobel_pkg::pixel_t pixel_o
);

    sobel_window_if winIf ();
    sobel_grad_if   gradIf ();

    // line buffers and the 3x3 window
    window_decode u_decode (
        .pclk_i  (pclk_i),
        .rstN_i  (rstN_i),
        .fsync_i (fsync_i),
        .rsync_i (rsync_i),
        .pixel_i (pixel_i),
        .win     (winIf.decode)
    );

    // Gx and Gy
    gradient_execute u_execute (
        .pclk_i (pclk_i),
        .rstN_i (rstN_i),
        .win    (winIf.execute),
        .grad   (gradIf.execute)
    );

    // magnitude and threshold
    edge_result u_result (
        .pclk_i  (pclk_i),
        .rstN_i  (rstN_i),
        .grad    (gradIf.result),
        .fsync_o (fsync_o),
        .rsync_o (rsync_o),
        .pixel_o (pixel_o)
    );

endmodule

// File: verilog/gradient_execute.sv
// execute stage of the Sobel pipeline
// registered Gx and Gy weighted sums over the 3x3 window
`timescale 1ns/1ps

module gradient_execute (
    input  logic            pclk_i,
    input  logic            rstN_i,
    sobel_window_if.execute win,
    sobel_grad_if.execute   grad
);

    localparam int PadWidth = $bits(sobel_pkg::grad_t) - $bits(sobel_pkg::pixel_t);

    logic             winValid;
    sobel_pkg::grad_t gxNext;
    sobel_pkg::grad_t gyNext;

    // zero extend a pixel into the signed gradient width
    function automatic sobel_pkg::grad_t widen(input sobel_pkg::pixel_t pix);
        return {{PadWidth{1'b0}}, pix};
    endfunction

    assign winValid = win.fsync && win.rsync;

    // right column minus left column, centre row weighted by 2
    assign gxNext = (widen(win.tap13) + (widen(win.tap23) <<< 1) + widen(win.tap33))
                  - (widen(win.tap11) + (widen(win.tap21) <<< 1) + widen(win.tap31));

    // bottom row minus top row, centre column weighted by 2
    assign gyNext = (widen(win.tap31) + (widen(win.tap32) <<< 1) + widen(win.tap33))
                  - (widen(win.tap11) + (widen(win.tap12) <<< 1) + widen(win.tap13));

    // syncs always move on, one cycle behind the window
    always_ff @(posedge pclk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            grad.fsync <= 1'b0;
            grad.rsync <= 1'b0;
        end else begin
            grad.fsync <= win.fsync;
            grad.rsync <= win.rsync;
        end
    end

    // gradients hold through blanking
    always_ff @(posedge pclk_i) begin
        if (winValid) begin
            grad.gx <= gxNext;
            grad.gy <= gyNext;
        end
    end

endmodule

// File: verilog/sobel_grad_if.sv
// Gx and Gy gradients with their syncs, execute stage to result stage
`timescale 1ns/1ps

interface sobel_grad_if;

    // horizontal and vertical gradient of one window
    sobel_pkg::grad_t gx;
    sobel_pkg::grad_t gy;

    // frame and line syncs, one cycle behind the window
    logic fsync;
    logic rsync;

    modport execute (
        output gx, gy,
        output fsync, rsync
    );

    modport result (
        input gx, gy,
        input fsync, rsync
    );

endinterface

// File: verilog/sobel_pkg.sv
// shared types of the Sobel pipeline
// pixel, gradient, magnitude, column and row counters
`include "sobel_settings.svh"

package sobel_pkg;

    // one video pixel
    typedef logic [`PIXEL_WIDTH-1:0] pixel_t;

    // signed Gx or Gy, range is +/-1020
    typedef logic signed [11:0] grad_t;

    // |Gx| + |Gy|, never more than 2040
    typedef logic [11:0] mag_t;

    // column index inside one line
    typedef logic [$clog2(`MAX_LINE_WIDTH)-1:0] col_t;

    // row index, saturates at 2
    typedef logic [1:0] row_t;

endpackage

// File: verilog/sobel_window_if.sv
// 3x3 pixel window and its syncs, decode stage to execute stage
`timescale 1ns/1ps

interface sobel_window_if;

    // tapRC: row R, column C, row 3 and column 3 hold the newest pixel
    sobel_pkg::pixel_t tap11;
    sobel_pkg::pixel_t tap12;
    sobel_pkg::pixel_t tap13;
    sobel_pkg::pixel_t tap21;
    sobel_pkg::pixel_t tap22;
    sobel_pkg::pixel_t tap23;
    sobel_pkg::pixel_t tap31;
    sobel_pkg::pixel_t tap32;
    sobel_pkg::pixel_t tap33;
    logic              fsync;
    logic              rsync;

    modport decode (
        output tap11, tap12, tap13, tap21, tap22, tap23, tap31, tap32, tap33,
        output fsync, rsync
    );

    modport execute (
        input tap11, tap12, tap13, tap21, tap22, tap23, tap31, tap32, tap33,
        input fsync, rsync
    );

endinterface

// File: verilog/window_decode.sv
// decode stage of the Sobel pipeline
// two line buffers, row and column counters, 3x3 window with zero border
`timescale 1ns/1ps
`include "sobel_settings.svh"

module window_decode (
    input  logic                 pclk_i,
    input  logic                 rstN_i,
    input  logic                 fsync_i,
    input  logic                 rsync_i,
    input  sobel_pkg::pixel_t    pixel_i,
    sobel_window_if.decode       win
);

    // line buffers, buffer 1 holds the row above, buffer 2 the row above that
    sobel_pkg::pixel_t lineBuf1 [`MAX_LINE_WIDTH];
    sobel_pkg::pixel_t lineBuf2 [`MAX_LINE_WIDTH];

    sobel_pkg::col_t   colCnt;
    sobel_pkg::row_t   rowCnt;
    logic              pixValid;
    sobel_pkg::pixel_t lb1Rd;
    sobel_pkg::pixel_t lb2Rd;
    sobel_pkg::pixel_t upperPix;
    sobel_pkg::pixel_t midPix;

    assign pixValid = fsync_i && rsync_i;

    // both buffers are read at the current column
    assign lb1Rd = lineBuf1[colCnt];
    assign lb2Rd = lineBuf2[colCnt];

    // rows above the first frame row read as zero
    assign upperPix = (rowCnt == 2'd2) ? lb2Rd : '0;
    assign midPix   = (rowCnt != 2'd0) ? lb1Rd : '0;

    // counters and sync delay
    always_ff @(posedge pclk_i or negedge rstN_i) begin
        if (!rstN_i) begin
            colCnt    <= '0;
            rowCnt    <= '0;
            win.fsync <= 1'b0;
            win.rsync <= 1'b0;
        end else begin
            win.fsync <= fsync_i;
            win.rsync <= rsync_i;

            // column restarts in every line blanking gap
            if (!rsync_i) begin
                colCnt <= '0;
            end else if (pixValid) begin
                colCnt <= colCnt + 1'b1;
            end

            // a falling rsync closes one line, only 0, 1 and 2+ matter
            if (!fsync_i) begin
                rowCnt <= '0;
            end else if (win.rsync && !rsync_i && rowCnt != 2'd2) begin
                rowCnt <= rowCnt + 1'b1;
            end
        end
    end

    // line buffer rotation
    always_ff @(posedge pclk_i) begin
        if (pixValid) begin
            lineBuf1[colCnt] <= pixel_i;
            lineBuf2[colCnt] <= lb1Rd;
        end
    end

    // window shift, the newest column enters at column 3
    always_ff @(posedge pclk_i) begin
        if (pixValid) begin
            if (colCnt == '0) begin
                // first pixel of a line, older columns lie left of the frame
                win.tap11 <= '0;
                win.tap12 <= '0;
                win.tap21 <= '0;
                win.tap22 <= '0;
                win.tap31 <= '0;
                win.tap32 <= '0;
            end else begin
                win.tap11 <= win.tap12;
                win.tap12 <= win.tap13;
                win.tap21 <= win.tap22;
                win.tap22 <= win.tap23;
                win.tap31 <= win.tap32;
                win.tap32 <= win.tap33;
            end
            win.tap13 <= upperPix;
            win.tap23 <= midPix;
            win.tap33 <= pixel_i;
        end
    end

endmodule
